/* tb.f */
+incdir+verilog
verilog/rv_mul_pkg.sv
verilog/mul_lane_if.sv
verilog/mul_unit.sv
verilog/mul_dispatch.sv
verilog/mul_collect.sv
verilog/mul_cluster.sv
test/tb_mul_cluster.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the multiply accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_mul_cluster
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_mul_cluster)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
  exit 0
fi
echo "Simulation did not pass"
exit 1

/* test/tb_mul_cluster.sv */
/*
 * Multiply accelerator testbench
 * Table-driven APB traffic against a reference multiply, with watchdog
 */
`default_nettype none

`include "rv_mul_consts.svh"

module tb_mul_cluster;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_mul_pkg::*;

  localparam int     CLK_PERIOD  = 100;
  localparam int     TABLE_LEN   = 32;
  localparam int     FIXED_LEN   = 16;           // Corner cases first, LCG entries after
  localparam int     MAX_POLLS   = `XLEN + 16;   // Status reads before giving up
  localparam longint WATCHDOG_NS = longint'(TABLE_LEN) * (`XLEN + 40) * CLK_PERIOD;

  logic        clk = 1'b0;
  logic        reset_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_addr_t   paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  // Stimulus and expected values
  mul_op_e     tbl_op  [TABLE_LEN];
  xlen_t       tbl_a   [TABLE_LEN];
  xlen_t       tbl_b   [TABLE_LEN];
  xlen_t       tbl_exp [TABLE_LEN];
  xlen_t       corner  [8];
  logic [31:0] lcg_state = 32'hb58ffc2f;

  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          test_start_err;
  string       test_name;

  mul_cluster i_mul_cluster (
    .clk     (clk),
    .reset_n (reset_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // RISC-V M rule on a 64-bit product of the extended operands
  function automatic xlen_t ref_mul(input mul_op_e op, input xlen_t a, input xlen_t b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] prod;
    ea   = (op == MULH || op == MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
    eb   = (op == MULH) ? {{32{b[31]}}, b} : {32'b0, b};
    prod = ea * eb;
    return (op == MUL) ? prod[31:0] : prod[63:32];
  endfunction

  task automatic check_result(input xlen_t got, input xlen_t exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_status(input lane_mask_t got_busy, input fifo_cnt_t got_cnt,
                              input lane_mask_t exp_busy, input fifo_cnt_t exp_cnt);
    checks++;
    if (got_busy !== exp_busy || got_cnt !== exp_cnt) begin
      $display("[ERROR] %0t: status busy %b count %0d expected busy %b count %0d",
               $time, got_busy, got_cnt, exp_busy, exp_cnt);
      errors++;
    end
  endtask

  task automatic check_error(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %0t: %s pslverr %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // One APB transfer, called and left at 1 ns after a rising edge
  task automatic apb_access(input logic write, input apb_addr_t addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1 penable = 1'b1;
    @(negedge clk);             // Mid access phase
    rdata = prdata;
    err   = pslverr;
    if (pready !== 1'b1) begin
      $display("[ERROR] %0t: pready low in access phase", $time);
      errors++;
    end
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_status(output lane_mask_t busy, output fifo_cnt_t cnt);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b0, `REG_STATUS, 32'h0, rd, err);
    check_error(err, 1'b0, "status read");
    busy = rd[3:0];
    cnt  = rd[11:8];
  endtask

  task automatic issue(input int idx, output logic err);
    logic [31:0] rd;
    logic        e;
    apb_access(1'b1, `REG_OPA, tbl_a[idx], rd, e);
    check_error(e, 1'b0, "OPA write");
    apb_access(1'b1, `REG_OPB, tbl_b[idx], rd, e);
    check_error(e, 1'b0, "OPB write");
    apb_access(1'b1, `REG_CMD, {29'b0, 1'b0, tbl_op[idx]}, rd, err);
  endtask

  task automatic read_result(input int idx);
    logic [31:0] rd;
    logic        e;
    apb_access(1'b0, `REG_RESULT, 32'h0, rd, e);
    check_error(e, 1'b0, "result read");
    check_result(xlen_t'(rd), tbl_exp[idx], $sformatf("entry %0d %s", idx, tbl_op[idx].name()));
  endtask

  // Polls until the FIFO holds target entries, or until a lane is free
  task automatic wait_status(input logic for_free, input fifo_cnt_t target);
    lane_mask_t busy;
    fifo_cnt_t  cnt;
    int         n;
    logic       waiting;
    n = 0;
    read_status(busy, cnt);
    waiting = for_free ? (busy == '1) : (cnt < target);
    while (waiting && n < MAX_POLLS) begin
      read_status(busy, cnt);
      waiting = for_free ? (busy == '1) : (cnt < target);
      n++;
    end
    if (waiting) begin
      $display("Gave up at %0t waiting for %s", $time,
               for_free ? "a free lane" : $sformatf("FIFO count %0d", target));
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name      = name;
    test_start_err = errors;
    tests_run++;
  endtask

  task automatic end_test();
    $display("test %0d %s: %0d error(s)", tests_run, test_name, errors - test_start_err);
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    lane_mask_t  busy;
    fifo_cnt_t   cnt;
    $timeformat(-9, 0, " ns", 0);
    reset_n = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;

    corner = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000,
               32'h7fff_ffff, 32'hffff_fffe, 32'h0000_0003, 32'h8000_0001};
    for (int i = 0; i < FIXED_LEN; i++) begin
      tbl_op[i] = mul_op_e'(2'(i % 4));
      tbl_a[i]  = corner[i % 8];
      tbl_b[i]  = corner[(3 * i + i / 8 + 3) % 8];  // Mixes signs across the set
    end
    for (int i = FIXED_LEN; i < TABLE_LEN; i++) begin
      lcg_state = lcg_next(lcg_state);
      tbl_op[i] = mul_op_e'(lcg_state[17:16]);
      lcg_state = lcg_next(lcg_state);
      tbl_a[i]  = lcg_state;
      lcg_state = lcg_next(lcg_state);
      tbl_b[i]  = lcg_state;
    end
    for (int i = 0; i < TABLE_LEN; i++) tbl_exp[i] = ref_mul(tbl_op[i], tbl_a[i], tbl_b[i]);

    repeat (3) @(posedge clk);
    #1 reset_n = 1'b1;

    begin_test("reset state");
    read_status(busy, cnt);
    check_status(busy, cnt, '0, '0);
    apb_access(1'b0, `REG_RESULT, 32'h0, rd, err);
    check_error(err, 1'b1, "empty result read");
    check_result(xlen_t'(rd), '0, "empty result data");
    end_test();

    begin_test("single commands");
    for (int i = 0; i < TABLE_LEN; i++) begin
      issue(i, err);
      check_error(err, 1'b0, "command");
      wait_status(1'b0, 4'd1);
      read_result(i);
    end
    end_test();

    begin_test("parallel issue");
    for (int i = 0; i < `MUL_LANES; i++) begin
      issue(i, err);
      check_error(err, 1'b0, "command");
    end
    read_status(busy, cnt);
    check_status(busy, cnt, '1, '0);
    issue(`MUL_LANES, err);
    check_error(err, 1'b1, "command with all lanes busy");
    wait_status(1'b0, fifo_cnt_t'(`MUL_LANES));
    for (int i = 0; i < `MUL_LANES; i++) read_result(i);
    read_status(busy, cnt);
    check_status(busy, cnt, '0, '0);
    end_test();

    begin_test("fifo back-pressure");
    for (int i = 0; i < `RESULT_DEPTH; i++) begin
      wait_status(1'b1, '0);
      issue(i, err);
      check_error(err, 1'b0, "command");
    end
    wait_status(1'b0, fifo_cnt_t'(`RESULT_DEPTH));
    issue(`RESULT_DEPTH, err);
    check_error(err, 1'b1, "command with FIFO full");
    read_status(busy, cnt);
    check_status(busy, cnt, '0, fifo_cnt_t'(`RESULT_DEPTH));
    for (int i = 0; i < `RESULT_DEPTH; i++) read_result(i);
    read_status(busy, cnt);
    check_status(busy, cnt, '0, '0);
    end_test();

    begin_test("random stream");
    for (int g = FIXED_LEN; g < TABLE_LEN; g += `MUL_LANES) begin
      for (int i = g; i < g + `MUL_LANES && i < TABLE_LEN; i++) begin
        issue(i, err);
        check_error(err, 1'b0, "command");
      end
      wait_status(1'b0, fifo_cnt_t'(`MUL_LANES));
      for (int i = g; i < g + `MUL_LANES && i < TABLE_LEN; i++) read_result(i);
    end
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/mul_cluster.sv */
/*
 * Multiply accelerator top level
 * APB dispatcher, four multiplier lanes and the in-order result collector
 */
`default_nettype none

`include "rv_mul_consts.svh"

module mul_cluster (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  rv_mul_pkg::apb_addr_t paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr
);
  import rv_mul_pkg::*;

  mul_lane_if lane_bus [`MUL_LANES] ();

  logic      order_push;
  lane_idx_t order_lane;
  fifo_cnt_t fifo_count;
  xlen_t     result_head;
  logic      fifo_pop;

  mul_dispatch i_dispatch (
    .clk         (clk),
    .reset_n     (reset_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .lanes       (lane_bus),
    .order_push  (order_push),
    .order_lane  (order_lane),
    .fifo_count  (fifo_count),
    .result_head (result_head),
    .fifo_pop    (fifo_pop)
  );

  generate
    for (genvar g = 0; g < `MUL_LANES; g++) begin : g_lane
      mul_unit i_lane (
        .clk     (clk),
        .reset_n (reset_n),
        .lane    (lane_bus[g])
      );
    end
  endgenerate

  mul_collect i_collect (
    .clk         (clk),
    .reset_n     (reset_n),
    .lanes       (lane_bus),
    .order_push  (order_push),
    .order_lane  (order_lane),
    .fifo_pop    (fifo_pop),
    .fifo_count  (fifo_count),
    .result_head (result_head)
  );

endmodule

`default_nettype wire

/* verilog/mul_collect.sv */
/*
 * Result collector
 * Retires lanes in issue order into the result FIFO and serves pops
 */
`default_nettype none

`include "rv_mul_consts.svh"

module mul_collect (
  input  logic                  clk,
  input  logic                  reset_n,
  mul_lane_if.collect           lanes [`MUL_LANES],
  input  logic                  order_push,
  input  rv_mul_pkg::lane_idx_t order_lane,
  input  logic                  fifo_pop,
  output rv_mul_pkg::fifo_cnt_t fifo_count,
  output rv_mul_pkg::xlen_t     result_head
);
  import rv_mul_pkg::*;

  localparam int PTR_W = $clog2(`RESULT_DEPTH);
  localparam int OCNT_W = $clog2(`MUL_LANES) + 1;

  // One lane holds at most one command, so the order queue needs MUL_LANES slots
  lane_idx_t         ord_q [`MUL_LANES];
  lane_idx_t         ord_wr_q;
  lane_idx_t         ord_rd_q;
  logic [OCNT_W-1:0] ord_cnt_q;

  xlen_t             fifo_mem [`RESULT_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  fifo_cnt_t         count_q;

  lane_mask_t        valid_vec;
  xlen_t             res_vec [`MUL_LANES];
  lane_idx_t         head_lane;
  logic              take;

  generate
    for (genvar g = 0; g < `MUL_LANES; g++) begin : g_lane
      assign valid_vec[g]  = lanes[g].valid;
      assign res_vec[g]    = lanes[g].result;
      assign lanes[g].ack  = take && (head_lane == lane_idx_t'(g));
    end
  endgenerate

  assign head_lane = ord_q[ord_rd_q];

  // Oldest lane only, and only with room in the FIFO
  assign take = (ord_cnt_q != '0) && valid_vec[head_lane] &&
                (count_q != fifo_cnt_t'(`RESULT_DEPTH));

  always_ff @(posedge clk) begin
    if (order_push) ord_q[ord_wr_q] <= order_lane;
    if (take) fifo_mem[wr_ptr_q] <= res_vec[head_lane];
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ord_wr_q  <= '0;
      ord_rd_q  <= '0;
      ord_cnt_q <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
    end else begin
      if (order_push) ord_wr_q <= ord_wr_q + 1'b1;
      if (take) ord_rd_q <= ord_rd_q + 1'b1;
      case ({order_push, take})
        2'b10:   ord_cnt_q <= ord_cnt_q + 1'b1;
        2'b01:   ord_cnt_q <= ord_cnt_q - 1'b1;
        default: ;
      endcase

      if (take) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (fifo_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({take, fifo_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  assign fifo_count  = count_q;
  assign result_head = fifo_mem[rd_ptr_q];

endmodule

`default_nettype wire

/* verilog/mul_dispatch.sv */
/*
 * APB register file and command dispatcher
 * Latches operands, issues commands to the lowest free lane, serves reads
 */
`default_nettype none

`include "rv_mul_consts.svh"

module mul_dispatch (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  rv_mul_pkg::apb_addr_t paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  mul_lane_if.dispatch          lanes [`MUL_LANES],
  output logic                  order_push,
  output rv_mul_pkg::lane_idx_t order_lane,
  input  rv_mul_pkg::fifo_cnt_t fifo_count,
  input  rv_mul_pkg::xlen_t     result_head,
  output logic                  fifo_pop
);
  import rv_mul_pkg::*;

  xlen_t      opa_q;
  xlen_t      opb_q;
  fifo_cnt_t  outstanding_q;   // Issued but not yet popped
  lane_mask_t busy_vec;
  lane_idx_t  free_idx;
  logic       free_found;
  logic       wr_acc;
  logic       rd_acc;
  logic       cmd_wr;
  logic       issue;
  logic       rd_result;
  logic       empty_err;

  assign wr_acc    = psel && penable && pwrite;
  assign rd_acc    = psel && penable && !pwrite;
  assign cmd_wr    = wr_acc && (paddr == `REG_CMD);
  assign rd_result = rd_acc && (paddr == `REG_RESULT);

  // Lowest-numbered idle lane wins
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = `MUL_LANES - 1; i >= 0; i--) begin
      if (!busy_vec[i]) begin
        free_found = 1'b1;
        free_idx   = lane_idx_t'(i);
      end
    end
  end

  assign issue     = cmd_wr && free_found &&
                     (outstanding_q != fifo_cnt_t'(`RESULT_DEPTH));
  assign empty_err = rd_result && (fifo_count == '0);
  assign fifo_pop  = rd_result && (fifo_count != '0);

  assign order_push = issue;
  assign order_lane = free_idx;

  // No wait states, errors flagged in the access phase
  assign pready  = 1'b1;
  assign pslverr = (cmd_wr && !issue) || empty_err;

  generate
    for (genvar g = 0; g < `MUL_LANES; g++) begin : g_lane
      assign busy_vec[g]        = lanes[g].busy;
      assign lanes[g].start     = issue && (free_idx == lane_idx_t'(g));
      assign lanes[g].op        = mul_op_e'(pwdata[1:0]);
      assign lanes[g].word_op   = pwdata[2];
      assign lanes[g].operand_a = opa_q;
      assign lanes[g].operand_b = opb_q;
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (wr_acc && (paddr == `REG_OPA)) opa_q <= xlen_t'(pwdata);
    if (wr_acc && (paddr == `REG_OPB)) opb_q <= xlen_t'(pwdata);
  end

  // Issue and pop never share a cycle, one APB access at a time
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      outstanding_q <= '0;
    end else if (issue) begin
      outstanding_q <= outstanding_q + 1'b1;
    end else if (fifo_pop) begin
      outstanding_q <= outstanding_q - 1'b1;
    end
  end

  always_comb begin
    prdata = '0;
    if (rd_acc) begin
      case (paddr)
        `REG_STATUS: begin
          prdata[`MUL_LANES-1:0] = busy_vec;
          prdata[11:8]           = fifo_count;
        end
        `REG_RESULT: if (!empty_err) prdata = result_head[31:0];
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/mul_unit.sv */
/*
 * Sequential multiplier lane
 * Add-and-shift over a double-width product for MUL, MULH, MULHSU, MULHU
 * and the RV64 word form, result held until the collector acks it
 */
`default_nettype none

`include "rv_mul_consts.svh"

module mul_unit (
  input  logic    clk,
  input  logic    reset_n,
  mul_lane_if.lane lane
);
  import rv_mul_pkg::*;

  localparam int CNT_W = $clog2(`XLEN + 1);

  mul_state_e state_q;
  logic       busy_q;
  logic       valid_q;

  // Datapath
  logic [2*`XLEN-1:0] product_q;
  logic [2*`XLEN-1:0] mcand_q;
  xlen_t              mplier_q;
  logic [CNT_W-1:0]   cnt_q;
  logic [CNT_W-1:0]   limit;
  logic               neg_q;      // Product sign
  mul_op_e            op_q;
  logic               word_op_q;
  xlen_t              result_q;

  xlen_t              a_in;
  xlen_t              b_in;
  xlen_t              abs_a;
  xlen_t              abs_b;
  logic               negate_a;
  logic               negate_b;
  logic [2*`XLEN-1:0] product_fix;
  xlen_t              sel_res;
  xlen_t              final_res;

  // Word ops only see the low 32 bits
  generate
    if (`XLEN == 64) begin : g_word_in
      assign a_in = lane.word_op ? {32'b0, lane.operand_a[31:0]} : lane.operand_a;
      assign b_in = lane.word_op ? {32'b0, lane.operand_b[31:0]} : lane.operand_b;
    end else begin : g_full_in
      assign a_in = lane.operand_a;
      assign b_in = lane.operand_b;
    end
  endgenerate

  // MULH and MULHSU treat A as signed, only MULH treats B as signed
  assign negate_a = ((lane.op == MULH) || (lane.op == MULHSU)) && a_in[`XLEN-1];
  assign negate_b = (lane.op == MULH) && b_in[`XLEN-1];
  assign abs_a    = negate_a ? (~a_in + 1'b1) : a_in;
  assign abs_b    = negate_b ? (~b_in + 1'b1) : b_in;

  assign limit = word_op_q ? CNT_W'(32) : CNT_W'(`XLEN);

  // Restore sign, then pick a half
  assign product_fix = neg_q ? (~product_q + 1'b1) : product_q;
  assign sel_res     = (op_q == MUL) ? product_fix[`XLEN-1:0]
                                     : product_fix[2*`XLEN-1:`XLEN];

  generate
    if (`XLEN == 64) begin : g_word_out
      assign final_res = word_op_q ? {{32{sel_res[31]}}, sel_res[31:0]} : sel_res;
    end else begin : g_full_out
      assign final_res = sel_res;
    end
  endgenerate

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= IDLE;
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (lane.start) begin
            state_q <= COMPUTE;
            busy_q  <= 1'b1;
          end
        end
        COMPUTE: begin
          if (cnt_q == limit) state_q <= DONE;  // limit+1 passes
        end
        DONE: begin
          if (valid_q && lane.ack) begin      // Retire
            state_q <= IDLE;
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
          end else begin
            valid_q <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state_q)
      IDLE: begin
        if (lane.start) begin
          product_q <= '0;
          mcand_q   <= {{`XLEN{1'b0}}, abs_a};
          mplier_q  <= abs_b;
          cnt_q     <= '0;
          neg_q     <= negate_a ^ negate_b;
          op_q      <= lane.op;
          word_op_q <= lane.word_op;
        end
      end
      COMPUTE: begin
        if (mplier_q[0]) product_q <= product_q + mcand_q;
        mcand_q  <= mcand_q << 1;
        mplier_q <= mplier_q >> 1;
        cnt_q    <= cnt_q + 1'b1;
      end
      DONE: begin
        if (!valid_q) result_q <= final_res;  // Capture once
      end
      default: ;
    endcase
  end

  assign lane.busy   = busy_q;
  assign lane.valid  = valid_q;
  assign lane.result = result_q;

endmodule

`default_nettype wire

/* verilog/mul_lane_if.sv */
/*
 * Multiplier lane bus
 * Command from the dispatcher, result and handshake to the collector
 */
`default_nettype none

interface mul_lane_if;
  import rv_mul_pkg::*;

  // Command side
  logic    start;      // One-cycle issue pulse
  mul_op_e op;
  logic    word_op;    // RV64 W form
  xlen_t   operand_a;
  xlen_t   operand_b;

  // Result side
  logic    busy;       // High from load until retire
  xlen_t   result;
  logic    valid;      // Held until ack
  logic    ack;

  modport dispatch (
    output start, op, word_op, operand_a, operand_b,
    input  busy
  );

  modport lane (
    input  start, op, word_op, operand_a, operand_b, ack,
    output busy, result, valid
  );

  modport collect (
    input  valid, result,
    output ack
  );

endinterface

`default_nettype wire

/* verilog/rv_mul_pkg.sv */
/*
 * Multiply accelerator types
 * Shared vectors and enums for the lanes, dispatcher and collector
 */
`default_nettype none

`include "rv_mul_consts.svh"

package rv_mul_pkg;

  typedef logic [`XLEN-1:0] xlen_t;        // Operand or result

  // Encoding matches funct3[1:0] of the M extension
  typedef enum logic [1:0] {
    MUL    = 2'b00,  // Low half
    MULH   = 2'b01,  // High half, signed x signed
    MULHSU = 2'b10,  // High half, signed x unsigned
    MULHU  = 2'b11   // High half, unsigned x unsigned
  } mul_op_e;

  typedef logic [1:0]            lane_idx_t;
  typedef logic [3:0]            fifo_cnt_t;   // 0 to RESULT_DEPTH
  typedef logic [`MUL_LANES-1:0] lane_mask_t;
  typedef logic [7:0]            apb_addr_t;

  // Lane sequencing
  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    COMPUTE = 2'b01,
    DONE    = 2'b10
  } mul_state_e;

endpackage

`default_nettype wire

/* verilog/rv_mul_consts.svh */
/*
 * Multiply accelerator constants
 * Data width, lane count, result FIFO depth and APB register map
 */
`ifndef RV_MUL_CONSTS_SVH
`define RV_MUL_CONSTS_SVH

// Core data width, 32 or 64
`define XLEN 32

`define MUL_LANES    4  // Parallel multiplier lanes
`define RESULT_DEPTH 8  // Result FIFO entries

// APB register offsets
`define REG_OPA    8'h00
`define REG_OPB    8'h04
`define REG_CMD    8'h08
`define REG_STATUS 8'h0C
`define REG_RESULT 8'h10

`endif
